/* Bender.yml */
package:
  name: obj_engine

sources:
  - files:
      - design/obj_pkg.sv
      - design/obj_table.sv
      - design/obj_scan.sv
      - design/obj_draw.sv
      - design/obj_rom_arb.sv
      - design/obj_line_buf.sv
      - design/obj_engine.sv
  - target: test
    files:
      - bench/obj_rom_model.sv
      - bench/obj_engine_tb.sv

/* bench/obj_engine_tb.sv */
// ********************************************************************
// Sprite engine testbench: table access, line drawing and readout
// ********************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_engine_tb import obj_pkg::*; ();

    localparam int CLK_P   = 40;
    localparam int N_LINES = 8;   // Lines of work, sizes the watchdog

    logic              clk;
    logic              rst;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    logic              hstart;
    logic [7:0]        vline;
    logic              line_busy;
    logic              rom_cs;
    logic [ROM_AW-1:0] rom_addr;
    logic [15:0]       rom_data;
    logic              rom_ok;
    logic [8:0]        pix_addr;
    logic [11:0]       pix_data;

    int          errors;
    int          checks;
    logic [15:0] tbl [4*N_OBJ];   // Shadow of the object table
    logic [11:0] exp_line [LINE_W];

    initial begin
        clk = 1'b0;
        forever #(CLK_P / 2) clk = ~clk;
    end

    obj_engine dut0 (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .hstart    (hstart),
        .vline     (vline),
        .line_busy (line_busy),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .pix_addr  (pix_addr),
        .pix_data  (pix_data)
    );

    obj_rom_model rom0 (
        .clk  (clk),
        .rst  (rst),
        .cs   (rom_cs),
        .addr (rom_addr),
        .data (rom_data),
        .ok   (rom_ok)
    );

    task automatic note_error(input string msg);
        errors++;
        $display("[FAIL] %0t %s", $time, msg);
    endtask

    // Bus and ROM handshake rules
    assert property (@(posedge clk) disable iff (rst)
        (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack)
        else note_error("ack missing one cycle after stb");
    assert property (@(posedge clk) disable iff (rst) wb_rsp.ack |=> !wb_rsp.ack)
        else note_error("ack longer than one cycle");
    assert property (@(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok) |=> (rom_cs && $stable(rom_addr)))
        else note_error("rom_cs or rom_addr changed before rom_ok");

    task automatic wb_cycle(input logic we, input logic [5:0] adr,
                            input logic [15:0] wdat, output logic [15:0] rdat);
        int n;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_rsp.ack && n < 20);
        checks++;
        assert (n == 1) else note_error($sformatf("ack after %0d cycles", n));
        rdat       = wb_rsp.dat;
        wb_req.cyc = 1'b0;   // Drop stb after ack
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    // Write, then read back the same word
    task automatic wb_write_check(input logic [5:0] adr, input logic [15:0] val);
        logic [15:0] rd;
        wb_cycle(1'b1, adr, val, rd);
        wb_cycle(1'b0, adr, 16'h0000, rd);
        checks++;
        assert (rd == val)
            else note_error($sformatf("word %0d read %h wrote %h", adr, rd, val));
        tbl[adr] = val;
    endtask

    task automatic set_obj(input int idx, input logic [7:0] top, input logic [7:0] height,
                           input logic [4:0] hz, input logic [1:0] prio,
                           input logic [8:0] x, input logic [15:0] off,
                           input logic [2:0] bank, input logic [5:0] pal,
                           input logic [6:0] pitch);
        logic [3:0] e;
        e = 4'(idx);
        wb_write_check({e, 2'd0}, {top, height});
        wb_write_check({e, 2'd1}, {hz, prio, x});
        wb_write_check({e, 2'd2}, off);
        wb_write_check({e, 2'd3}, {bank, pal, pitch});
    endtask

    task automatic clear_table();
        for (int i = 0; i < N_OBJ; i++) begin
            wb_write_check({4'(i), 2'd0}, 16'h0000); // Height 0 disables
        end
    endtask

    task automatic put_pixel(input logic [8:0] x, input logic [11:0] val);
        if (x < 9'(LINE_W)) begin
            if (exp_line[x] == 12'h000 || val[11:10] > exp_line[x][11:10]) begin
                exp_line[x] = val;
            end
        end
    endtask

    // One sprite row drawn by the flip and zoom rules
    task automatic model_sprite(input logic [15:0] w1, input logic [15:0] w2,
                                input logic [15:0] w3, input logic [7:0] rel);
        logic [14:0] cur;
        logic [8:0]  x;
        logic [5:0]  acc;
        logic [6:0]  sum;
        logic [15:0] word;
        logic [3:0]  p;
        logic        flip;
        logic        done;
        int          guard;
        flip  = w2[15];
        cur   = 15'(w2[14:0] + rel * w3[6:0]);   // Wraps in 15 bits
        x     = w1[8:0];
        acc   = {w1[14:11], 2'b00};
        done  = 1'b0;
        guard = 0;
        while (!done && guard < 64) begin
            word = rom0.word_at({2'b00, w3[14:13], w3[15], cur});
            for (int k = 0; k < 4; k++) begin
                p   = flip ? word[4*k +: 4] : word[12-4*k +: 4];
                sum = {1'b0, acc} + {2'b00, w1[15:11]};
                acc = sum[5:0];
                if (!sum[6]) begin
                    if (p != 4'hF) put_pixel(x, {w1[10:9], w3[12:7], p});
                    x = x + 1'b1;
                end
                if (k == 3 && p == 4'hF) done = 1'b1;
            end
            cur = flip ? cur - 1'b1 : cur + 1'b1;
            guard++;
        end
    endtask

    task automatic build_expected(input logic [7:0] line);
        logic [7:0] top;
        logic [7:0] h;
        for (int a = 0; a < LINE_W; a++) exp_line[a] = 12'h000;
        for (int e = 0; e < N_OBJ; e++) begin
            top = tbl[4*e][15:8];
            h   = tbl[4*e][7:0];
            if (h != 0 && line >= top && {1'b0, line} < {1'b0, top} + {1'b0, h}) begin
                model_sprite(tbl[4*e+1], tbl[4*e+2], tbl[4*e+3], line - top);
            end
        end
    endtask

    // Read the display half, one address per cycle, data a cycle later
    task automatic read_check(input bit zero);
        logic [11:0] expv;
        for (int a = 0; a <= LINE_W; a++) begin
            if (a > 0) begin
                expv = zero ? 12'h000 : exp_line[a-1];
                checks++;
                assert (pix_data == expv)
                    else note_error($sformatf("pixel %0d got %h expected %h",
                                              a - 1, pix_data, expv));
            end
            pix_addr = (a < LINE_W) ? 9'(a) : 9'h1FF; // Park out of range
            @(negedge clk);
        end
    endtask

    // One cycle hstart, swaps the halves
    task automatic pulse_hstart(input logic [7:0] line);
        @(negedge clk);
        hstart = 1'b1;
        vline  = line;
        @(negedge clk);
        hstart = 1'b0;
    endtask

    task automatic run_line(input logic [7:0] line);
        int n;
        build_expected(line);
        pulse_hstart(line);
        n = 0;
        while (line_busy && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (line_busy) begin
            errors++;
            $display("line_busy never fell while drawing line %0d", line);
        end
        pulse_hstart(8'd255);  // Idle line, nothing covers it
        read_check(1'b0);
        read_check(1'b1); // Readout cleared every slot
    endtask

    initial begin
        #(N_LINES * 2000 * CLK_P);
        $display("Timeout: the run did not finish within %0d cycles", N_LINES * 2000);
        $display("checks %0d, errors %0d", checks, errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        wb_req   = '0;
        hstart   = 1'b0;
        vline    = 8'd0;
        pix_addr = 9'h1FF;
        errors   = 0;
        checks   = 0;
        for (int i = 0; i < 4 * N_OBJ; i++) tbl[i] = 16'h0000;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        checks++;
        assert (!line_busy && !rom_cs && !wb_rsp.ack)
            else note_error("outputs not idle after reset");

        read_check(1'b1);   // Display half starts empty
        pulse_hstart(8'd255);
        read_check(1'b1);   // Other half starts empty too
        run_line(8'd200);

        // Every table word written and read back
        for (int i = 0; i < 4 * N_OBJ; i++) begin
            wb_write_check(6'(i), 16'(i * 16'h0413) ^ 16'hA5C3);
        end
        for (int i = 0; i < 4 * N_OBJ; i++) wb_write_check(6'(i), 16'h0000);

        // Single plain sprite, a disabled one, one off the line, one past the edge
        set_obj(0, 8'd10, 8'd20, 5'd0, 2'd1, 9'd40, 16'h0100, 3'd5, 6'h11, 7'd8);
        set_obj(1, 8'd0, 8'd0, 5'd0, 2'd3, 9'd80, 16'h0200, 3'd1, 6'h22, 7'd4);
        set_obj(2, 8'd100, 8'd10, 5'd0, 2'd3, 9'd120, 16'h0300, 3'd2, 6'h0C, 7'd4);
        set_obj(3, 8'd12, 8'd4, 5'd0, 2'd2, 9'd300, 16'h0330, 3'd2, 6'h2A, 7'd3);
        run_line(8'd15);

        // Flipped rows
        clear_table();
        set_obj(0, 8'd0, 8'd50, 5'd0, 2'd3, 9'd60, 16'h8203, 3'd3, 6'h05, 7'd4);
        set_obj(1, 8'd0, 8'd50, 5'd0, 2'd1, 9'd200, 16'h8457, 3'd6, 6'h31, 7'd2);
        run_line(8'd2);

        // Horizontal zoom
        clear_table();
        set_obj(0, 8'd20, 8'd8, 5'd9, 2'd2, 9'd10, 16'h0040, 3'd1, 6'h12, 7'd5);
        set_obj(1, 8'd20, 8'd8, 5'd31, 2'd1, 9'd150, 16'h8061, 3'd4, 6'h09, 7'd3);
        set_obj(2, 8'd18, 8'd9, 5'd20, 2'd3, 9'd250, 16'h0711, 3'd7, 6'h3E, 7'd1);
        run_line(8'd23);

        // Eight overlapping sprites, equal prio never overlaps
        clear_table();
        for (int i = 0; i < 8; i++) begin
            set_obj(i, 8'd30, 8'd16, (i == 5) ? 5'd7 : 5'd0, 2'(i % 4),
                    9'(100 + 8 * i), {i[0], 15'(16'h0500 + 16'h21 * i)},
                    3'(i), 6'(5 * i + 3), 7'd6);
        end
        run_line(8'd37);
        pulse_hstart(8'd255); // Next line drawn into the other half
        run_line(8'd45);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/obj_rom_model.sv */
// ********************************************************************
// Behavioural graphics ROM with random ok delay and address-derived data
// ********************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_rom_model import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cs,
    input  logic [ROM_AW-1:0] addr,
    output logic [15:0]       data,
    output logic              ok
);

    integer seed = 32'hdc28_fd5a; // Fixed seed, repeatable delays
    int     dly;
    int     wait_cnt;
    logic   pending;              // Request seen, ok not yet given

    // Word contents, every nibble depends on the whole address
    function automatic logic [15:0] word_at(input logic [ROM_AW-1:0] a);
        logic [3:0]  n [4];
        logic [15:0] w;
        for (int k = 0; k < 4; k++) begin
            n[k] = 4'((int'(a[14:0]) * 7 + k * 5 + int'(a[19:15]) * 3) % 15); // Never F
        end
        w = {n[3], n[2], n[1], n[0]};
        if (a[2:0] == 3'd7) begin
            w[15:12] = 4'hF;  // Ends a sprite in either direction
            w[3:0]   = 4'hF;
        end else if (a[2:0] == 3'd3) begin
            w[11:8] = 4'hF;   // Transparent gap inside a row
        end
        return w;
    endfunction

    always @(negedge clk or posedge rst) begin
        if (rst) begin
            ok       <= 1'b0;
            data     <= '0;
            pending  <= 1'b0;
            wait_cnt <= 0;
        end else begin
            ok <= 1'b0;
            if (ok) begin
                pending <= 1'b0;                  // Gap cycle after ok
            end else if (!cs) begin
                pending <= 1'b0;                  // Request withdrawn
            end else if (!pending) begin
                dly = $random(seed) & 3;          // 0 to 3 cycles
                if (dly == 0) begin
                    ok   <= 1'b1;
                    data <= word_at(addr);
                end else begin
                    pending  <= 1'b1;
                    wait_cnt <= dly - 1;
                end
            end else if (wait_cnt == 0) begin
                ok      <= 1'b1;
                data    <= word_at(addr);
                pending <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/obj_draw.sv */
// ********************************************************************
// Sprite draw unit: fetches graphics words, applies flip and zoom
// ********************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_draw import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              hstart,
    input  logic              start,
    input  obj_job_t          job,
    output logic              busy,
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ok,
    input  logic [15:0]       rom_data,
    output pix_wr_t           wr,
    input  logic              wr_ready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_DRAW
    } draw_st_t;

    draw_st_t    state;
    logic [1:0]  cnt;       // Pixel within the word
    obj_job_t    job_q;
    logic [15:0] cur;       // Word address, bit 15 is flip
    logic [15:0] pxl_data;
    logic [5:0]  hzacc;
    logic [8:0]  xaddr;
    logic        hflip;
    logic [3:0]  cur_pxl;
    logic [6:0]  hzsum;
    logic        hzov;
    logic        pix_on;
    logic        step;
    logic        last;

    assign hflip   = cur[15];
    assign cur_pxl = hflip ? pxl_data[3:0] : pxl_data[15:12];

    // Zoom accumulator, carry drops the pixel
    assign hzsum = {1'b0, hzacc} + {2'd0, job_q.hzoom};
    assign hzov  = hzsum[6];

    assign pix_on = ~hzov && (cur_pxl != 4'hF); // F is transparent
    assign step   = (state == S_DRAW) && (!pix_on || wr_ready); // Stall on back-pressure
    assign last   = (cnt == 2'd3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else if (hstart) begin
            state <= S_IDLE;  // Line over, drop any work
        end else if (start) begin
            state <= S_FETCH;
        end else begin
            case (state)
                S_FETCH: begin
                    if (rom_ok) begin
                        state <= S_DRAW;
                        cnt   <= '0;
                    end
                end
                S_DRAW: begin
                    if (step) begin
                        cnt <= cnt + 1'b1;
                        if (last) begin
                            // F in the last pixel ends the sprite
                            state <= (cur_pxl == 4'hF) ? S_IDLE : S_FETCH;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            job_q <= job;
            cur   <= job.offset;
            xaddr <= job.xpos;
            hzacc <= {job.hzoom[3:0], 2'd0};
        end else if (state == S_FETCH && rom_ok) begin
            pxl_data <= rom_data;
        end else if (step) begin
            hzacc <= hzsum[5:0];
            if (!hzov) xaddr <= xaddr + 1'b1; // Zoomed pixels close up
            pxl_data <= hflip ? {4'h0, pxl_data[15:4]} : {pxl_data[11:0], 4'h0};
            if (last) begin
                cur[14:0] <= hflip ? cur[14:0] - 15'd1 : cur[14:0] + 15'd1;
            end
        end
    end

    assign busy     = (state != S_IDLE);
    assign rom_cs   = (state == S_FETCH); // Falls the cycle after ok
    assign rom_addr = {2'b00, job_q.bank[1:0], job_q.bank[2], cur[14:0]};

    always_comb begin
        wr.valid = (state == S_DRAW) && pix_on;
        wr.addr  = xaddr;
        wr.prio  = job_q.prio;
        wr.pal   = job_q.pal;
        wr.pxl   = cur_pxl;
    end

endmodule

`default_nettype wire

/* design/obj_engine.sv */
// ********************************************************************
// Sprite line engine top: table, scanner, draw units, ROM arbiter
// ********************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_engine import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  wb_req_t           wb_req,
    output wb_rsp_t           wb_rsp,
    input  logic              hstart,
    input  logic [7:0]        vline,
    output logic              line_busy,
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic [15:0]       rom_data,
    input  logic              rom_ok,
    input  logic [8:0]        pix_addr,
    output logic [11:0]       pix_data
);

    logic [IDX_W-1:0]  rd_idx;
    obj_attr_t         rd_attr;
    logic [N_DRAW-1:0] unit_busy;
    logic [N_DRAW-1:0] unit_start;
    obj_job_t          job;
    logic              scan_done;
    logic [N_DRAW-1:0] unit_cs;
    logic [ROM_AW-1:0] unit_addr [N_DRAW];
    logic [N_DRAW-1:0] unit_ok;
    pix_wr_t           unit_wr [N_DRAW];
    logic [N_DRAW-1:0] unit_ready;

    assign line_busy = (|unit_busy) | ~scan_done; // Falls at end of drawing

    obj_table u_table (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .rd_idx  (rd_idx),
        .rd_attr (rd_attr)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .hstart    (hstart),
        .vline     (vline),
        .rd_idx    (rd_idx),
        .rd_attr   (rd_attr),
        .unit_busy (unit_busy),
        .start     (unit_start),
        .job       (job),
        .scan_done (scan_done)
    );

    for (genvar i = 0; i < N_DRAW; i++) begin : g_draw
        obj_draw u_draw (
            .clk      (clk),
            .rst      (rst),
            .hstart   (hstart),
            .start    (unit_start[i]),
            .job      (job),            // Shared job bus
            .busy     (unit_busy[i]),
            .rom_cs   (unit_cs[i]),
            .rom_addr (unit_addr[i]),
            .rom_ok   (unit_ok[i]),
            .rom_data (rom_data),
            .wr       (unit_wr[i]),
            .wr_ready (unit_ready[i])
        );
    end

    obj_rom_arb u_rom_arb (
        .clk      (clk),
        .rst      (rst),
        .req_cs   (unit_cs),
        .req_addr (unit_addr),
        .req_ok   (unit_ok),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok)
    );

    obj_line_buf u_line_buf (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .wr       (unit_wr),
        .wr_ready (unit_ready),
        .pix_addr (pix_addr),
        .pix_data (pix_data)
    );

endmodule

`default_nettype wire

/* design/obj_line_buf.sv */
// ********************************************************************
// Double-buffered line buffer with priority merge and read-and-clear
// ********************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_line_buf import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              hstart,
    input  pix_wr_t           wr [N_DRAW],
    output logic [N_DRAW-1:0] wr_ready,
    input  logic [8:0]        pix_addr,
    output logic [11:0]       pix_data
);

    logic [11:0]       line_mem [2][LINE_W]; // {prio, pal, pxl}, zero is empty
    logic              half;                 // Half being drawn
    logic [DRAW_W-1:0] rr_ptr;
    logic [N_DRAW-1:0] vld;
    logic [DRAW_W-1:0] pick;
    logic              any_wr;
    pix_wr_t           sel;
    logic              in_range;
    logic [11:0]       stored;
    logic              store;

    always_comb begin
        for (int i = 0; i < N_DRAW; i++) begin
            vld[i] = wr[i].valid;
        end
    end

    assign pick   = rr_pick(vld, rr_ptr);
    assign any_wr = |vld;
    assign sel    = wr[pick];

    always_comb begin
        wr_ready = '0;
        if (any_wr) wr_ready[pick] = 1'b1; // One accepted per cycle
    end

    assign in_range = (sel.addr < 9'(LINE_W));
    assign stored   = in_range ? line_mem[half][sel.addr] : 12'h000;
    // Empty slot or strictly higher prio wins
    assign store    = any_wr && !hstart && in_range &&
                      ((stored == 12'h000) || (sel.prio > stored[11:10]));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half     <= 1'b0;
            rr_ptr   <= '0;
            pix_data <= '0;
            for (int h = 0; h < 2; h++) begin
                for (int a = 0; a < LINE_W; a++) begin
                    line_mem[h][a] <= '0;
                end
            end
        end else begin
            if (hstart) half <= ~half;       // Swap draw and display
            if (any_wr) rr_ptr <= pick + 1'b1;
            if (store) line_mem[half][sel.addr] <= {sel.prio, sel.pal, sel.pxl};
            if (pix_addr < 9'(LINE_W)) begin
                pix_data <= line_mem[!half][pix_addr];
                line_mem[!half][pix_addr] <= '0; // Ready for the next line
            end else begin
                pix_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/obj_pkg.sv */
// ********************************************************************
// Sprite engine package: sizes, table and job types, shared helpers
// ********************************************************************
`default_nettype none

package obj_pkg;

    localparam int N_OBJ  = 16;              // Object table entries
    localparam int N_DRAW = 4;               // Draw units
    localparam int LINE_W = 320;             // Visible pixels per line
    localparam int IDX_W  = $clog2(N_OBJ);
    localparam int DRAW_W = $clog2(N_DRAW);
    localparam int ROM_AW = 20;              // Graphics ROM word address

    // One table entry, word 3 at the top down to word 0
    typedef struct packed {
        logic [2:0]  bank;   // Word 3
        logic [5:0]  pal;
        logic [6:0]  pitch;  // Words per sprite row
        logic [15:0] offset; // Word 2, bit 15 is hflip
        logic [4:0]  hzoom;  // Word 1
        logic [1:0]  prio;
        logic [8:0]  xpos;
        logic [7:0]  top;    // Word 0
        logic [7:0]  height; // Zero disables the entry
    } obj_attr_t;

    // Work handed from scanner to a draw unit
    typedef struct packed {
        logic [8:0]  xpos;
        logic [15:0] offset; // Row start, flip kept in bit 15
        logic [2:0]  bank;
        logic [1:0]  prio;
        logic [5:0]  pal;
        logic [4:0]  hzoom;
    } obj_job_t;

    typedef struct packed {
        logic       valid;
        logic [8:0] addr;
        logic [1:0] prio;
        logic [5:0] pal;
        logic [3:0] pxl;
    } pix_wr_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [5:0]  adr; // Entry in [5:2], word in [1:0]
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    // First requester at or after ptr, wrapping around
    function automatic logic [DRAW_W-1:0] rr_pick(input logic [N_DRAW-1:0] req,
                                                  input logic [DRAW_W-1:0] ptr);
        logic [DRAW_W-1:0] idx;
        logic [DRAW_W-1:0] sel;
        sel = ptr;
        for (int k = N_DRAW - 1; k >= 0; k--) begin
            idx = ptr + DRAW_W'(k);
            if (req[idx]) sel = idx; // Lowest distance wins last
        end
        return sel;
    endfunction

endpackage

`default_nettype wire

/* design/obj_rom_arb.sv */
// ********************************************************************
// Round-robin arbiter sharing the graphics ROM port among draw units
// ********************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_rom_arb import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [N_DRAW-1:0] req_cs,
    input  logic [ROM_AW-1:0] req_addr [N_DRAW],
    output logic [N_DRAW-1:0] req_ok,
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ok
);

    logic [DRAW_W-1:0] gnt;     // Unit owning the ROM port
    logic [N_DRAW-1:0] others;  // Requests excluding the owner

    assign rom_cs   = req_cs[gnt];
    assign rom_addr = req_addr[gnt];
    assign others   = req_cs & ~(N_DRAW'(1) << gnt);

    // ok goes back to the owner only
    always_comb begin
        req_ok      = '0;
        req_ok[gnt] = rom_ok & rom_cs;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gnt <= '0;
        end else if ((rom_ok || !req_cs[gnt]) && (|others)) begin
            gnt <= rr_pick(others, gnt + 1'b1); // Next in turn
        end
    end

endmodule

`default_nettype wire

/* design/obj_scan.sv */
// ********************************************************************
// Line scanner: finds sprites on the line and dispatches draw jobs
// ********************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_scan import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              hstart,
    input  logic [7:0]        vline,
    output logic [IDX_W-1:0]  rd_idx,
    input  obj_attr_t         rd_attr,
    input  logic [N_DRAW-1:0] unit_busy,
    output logic [N_DRAW-1:0] start,
    output obj_job_t          job,
    output logic              scan_done
);

    logic [IDX_W-1:0]  idx;
    logic              active;
    logic [N_DRAW-1:0] start_q;
    obj_job_t          job_q;
    logic [7:0]        rel;      // Line within the sprite
    logic [8:0]        bottom;
    logic              hit;
    logic [14:0]       row_off;
    logic [N_DRAW-1:0] idle;
    logic [DRAW_W-1:0] free_idx;
    logic              dispatch;

    assign rel    = vline - rd_attr.top;
    assign bottom = {1'b0, rd_attr.top} + {1'b0, rd_attr.height};
    assign hit    = (rd_attr.height != 8'd0) && (vline >= rd_attr.top) &&
                    ({1'b0, vline} < bottom);

    // Row start wraps in 15 bits
    assign row_off = rd_attr.offset[14:0] + 15'(rel * rd_attr.pitch);

    // Unit started last cycle shows busy only from next cycle
    assign idle = ~unit_busy & ~start_q;

    always_comb begin
        free_idx = '0;
        for (int i = N_DRAW - 1; i >= 0; i--) begin
            if (idle[i]) free_idx = DRAW_W'(i); // Lowest number wins
        end
    end

    assign dispatch = active && hit && (|idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx     <= '0;
            active  <= 1'b0;
            start_q <= '0;
        end else if (hstart) begin
            idx     <= '0;  // Restart from entry 0
            active  <= 1'b1;
            start_q <= '0;
        end else begin
            start_q <= '0;
            if (dispatch) start_q <= N_DRAW'(1) << free_idx;
            // A hit with no free unit holds the index
            if (active && (!hit || dispatch)) begin
                if (idx == IDX_W'(N_OBJ - 1)) begin
                    active <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            job_q.xpos   <= rd_attr.xpos;
            job_q.offset <= {rd_attr.offset[15], row_off}; // Flip kept
            job_q.bank   <= rd_attr.bank;
            job_q.prio   <= rd_attr.prio;
            job_q.pal    <= rd_attr.pal;
            job_q.hzoom  <= rd_attr.hzoom;
        end
    end

    assign rd_idx    = idx;
    assign start     = start_q;
    assign job       = job_q;
    // Held low until the last start has turned into busy
    assign scan_done = ~active & ~(|start_q) & ~hstart;

endmodule

`default_nettype wire

/* design/obj_table.sv */
// ********************************************************************
// Object attribute table, Wishbone classic slave with scanner read port
// ********************************************************************
`timescale 1ns/10ps
`default_nettype none

module obj_table import obj_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  wb_req_t          wb_req,
    output wb_rsp_t          wb_rsp,
    input  logic [IDX_W-1:0] rd_idx,
    output obj_attr_t        rd_attr
);

    logic [15:0] regs [4*N_OBJ]; // Four words per entry
    logic        wb_hit;

    // New cycle seen, not yet answered
    assign wb_hit = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_rsp.ack <= 1'b0;
            wb_rsp.dat <= '0;
            for (int i = 0; i < 4 * N_OBJ; i++) begin
                regs[i] <= '0; // All heights zero, table disabled
            end
        end else begin
            wb_rsp.ack <= wb_hit; // Single cycle ack
            if (wb_hit) begin
                if (wb_req.we) regs[wb_req.adr] <= wb_req.dat;
                wb_rsp.dat <= regs[wb_req.adr];
            end
        end
    end

    // Whole entry to the scanner, no latency
    assign rd_attr = {regs[{rd_idx, 2'd3}],
                      regs[{rd_idx, 2'd2}],
                      regs[{rd_idx, 2'd1}],
                      regs[{rd_idx, 2'd0}]};

endmodule

`default_nettype wire

/* obj_engine.f */
design/obj_pkg.sv
design/obj_table.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_rom_arb.sv
design/obj_line_buf.sv
design/obj_engine.sv
bench/obj_rom_model.sv
bench/obj_engine_tb.sv
